//--- verilog/fetch_obi_pkg.sv
// Shared constants and state encoding for the OBI instruction fetch subsystem
`default_nettype none

package fetch_obi_pkg;

  ////////////////////////////////////////////////////////////
  // Bus topology
  ////////////////////////////////////////////////////////////

  // Peer fetch adapters sharing one OBI bus
  localparam int NUM_FETCH_PORTS = 2;

  ////////////////////////////////////////////////////////////
  // Integrity checksums
  ////////////////////////////////////////////////////////////

  // Address phase checksum
  // [3:0] even parity per address byte
  // [4]   parity over prot and dbg
  // [5]   constant term for a read with all byte enables set
  localparam int ACHK_W = 6;

  // Response checksum
  // [3:0] even parity per rdata byte
  // [4]   even parity of err
  localparam int RCHK_W = 5;

  ////////////////////////////////////////////////////////////
  // Adapter FSM
  ////////////////////////////////////////////////////////////

  // TRANSPARENT passes the request straight to the bus
  // REGISTERED drives a waiting address phase from registers
  typedef enum logic {
    TRANSPARENT = 1'b0,
    REGISTERED  = 1'b1
  } obi_if_state_e;

endpackage

`default_nettype wire

//--- verilog/obi_rchk_check.sv
// Response checksum checker comparing recomputed rdata and err parities with rchk
`timescale 1ns/10ps
`default_nettype none

module obi_rchk_check (
  input  wire [31:0]                       rdata_i,
  input  wire                              err_i,
  input  wire [fetch_obi_pkg::RCHK_W-1:0] rchk_i,
  input  wire                              enable_i,
  output logic                             err_o
);

  import fetch_obi_pkg::*;

  // Checksum rebuilt from the received payload
  logic [RCHK_W-1:0] rchk_exp;

  ////////////////////////////////////////////////////////////
  // Recompute
  ////////////////////////////////////////////////////////////

  // Even parity per byte, lowest byte in bit 0
  assign rchk_exp[0] = ^rdata_i[7:0];
  assign rchk_exp[1] = ^rdata_i[15:8];
  assign rchk_exp[2] = ^rdata_i[23:16];
  assign rchk_exp[3] = ^rdata_i[31:24];

  // Error bit covered on its own
  assign rchk_exp[4] = ^err_i;

  ////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////

  // Only meaningful during a response with checking enabled
  assign err_o = enable_i && (rchk_exp != rchk_i);

endmodule

`default_nettype wire

//--- verilog/obi_instr_adapter.sv
// OBI instruction adapter holding the address phase until grant and flagging bus integrity errors
`timescale 1ns/10ps
`default_nettype none

module obi_instr_adapter #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  wire                              clk,
  input  wire                              rst_n,

  // Transaction request
  input  wire                              trans_valid_i,
  output logic                             trans_ready_o,
  input  wire [31:0]                       trans_addr_i,
  input  wire [2:0]                        trans_prot_i,
  input  wire                              trans_dbg_i,
  input  wire                              trans_integrity_i,

  // Transaction response, consumer always ready
  output logic                             resp_valid_o,
  output logic [31:0]                      resp_rdata_o,
  output logic                             resp_err_o,
  output logic                             resp_parity_err_o,
  output logic                             resp_rchk_err_o,
  output logic                             resp_integrity_o,

  output logic                             integrity_err_o,
  input  wire                              integrity_en_i,

  // OBI address phase
  output logic                             obi_req_o,
  output logic                             obi_reqpar_o,
  input  wire                              obi_gnt_i,
  input  wire                              obi_gntpar_i,
  output logic [31:0]                      obi_addr_o,
  output logic [2:0]                       obi_prot_o,
  output logic                             obi_dbg_o,
  output logic [fetch_obi_pkg::ACHK_W-1:0] obi_achk_o,

  // OBI response phase
  input  wire                              obi_rvalid_i,
  input  wire                              obi_rvalidpar_i,
  input  wire [31:0]                       obi_rdata_i,
  input  wire                              obi_err_i,
  input  wire [fetch_obi_pkg::RCHK_W-1:0] obi_rchk_i
);

  import fetch_obi_pkg::*;

  // Counter must reach MAX_OUTSTANDING
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  obi_if_state_e state_q;
  obi_if_state_e next_state;

  // Address phase captured while waiting for gnt
  logic [31:0] addr_q;
  logic [2:0]  prot_q;
  logic        dbg_q;
  logic        integrity_q;
  // PMA attribute belonging to the phase on the bus
  logic        integrity_a;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] next_cnt;
  logic             accept;

  logic gntpar_err;
  logic gntpar_err_q;
  logic rvalidpar_err;
  logic rchk_err;

  // Per-transfer flags, entry 1 is the newest and entry 0 stays low
  logic [MAX_OUTSTANDING:0] gnterr_fifo_q;
  logic [MAX_OUTSTANDING:0] integ_fifo_q;

  ////////////////////////////////////////////////////////////
  // Address phase FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    next_state = state_q;
    case (state_q)
      TRANSPARENT: begin
        // Not granted at once, hold the phase from registers
        if (obi_req_o && !obi_gnt_i) begin
          next_state = REGISTERED;
        end
      end
      REGISTERED: begin
        if (obi_gnt_i) begin
          next_state = TRANSPARENT;
        end
      end
      default: next_state = TRANSPARENT;
    endcase
  end

  always_comb begin
    if (state_q == TRANSPARENT) begin
      obi_req_o   = trans_valid_i;
      obi_addr_o  = trans_addr_i;
      obi_prot_o  = trans_prot_i;
      obi_dbg_o   = trans_dbg_i;
      integrity_a = trans_integrity_i;
    end else begin
      // Request is never retracted before gnt
      obi_req_o   = 1'b1;
      obi_addr_o  = addr_q;
      obi_prot_o  = prot_q;
      obi_dbg_o   = dbg_q;
      integrity_a = integrity_q;
    end
  end

  assign obi_reqpar_o  = ~obi_req_o;
  assign trans_ready_o = (state_q == TRANSPARENT);

  // Checksum over whatever is driven on the bus
  assign obi_achk_o = {
    ~^{4'b1111, 1'b0},           // be all set, we low
    ^{obi_prot_o, obi_dbg_o},
    ^obi_addr_o[31:24],
    ^obi_addr_o[23:16],
    ^obi_addr_o[15:8],
    ^obi_addr_o[7:0]
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TRANSPARENT;
    end else begin
      state_q <= next_state;
    end
  end

  // Capture on entry to REGISTERED
  always_ff @(posedge clk) begin
    if ((state_q == TRANSPARENT) && (next_state == REGISTERED)) begin
      addr_q      <= trans_addr_i;
      prot_q      <= trans_prot_i;
      dbg_q       <= trans_dbg_i;
      integrity_q <= trans_integrity_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outstanding transfers
  ////////////////////////////////////////////////////////////

  assign accept = obi_req_o && obi_gnt_i;

  always_comb begin
    case ({accept, obi_rvalid_i})
      2'b10:   next_cnt = cnt_q + 1'b1;
      2'b01:   next_cnt = cnt_q - 1'b1;
      default: next_cnt = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= next_cnt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Parity tracking
  ////////////////////////////////////////////////////////////

  // Parity bits are the inverse of their signal
  assign gntpar_err    = (obi_gnt_i == obi_gntpar_i);
  assign rvalidpar_err = (obi_rvalid_i == obi_rvalidpar_i);

  // Sticky over a waited phase, cleared at the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gntpar_err_q <= 1'b0;
    end else if (obi_req_o) begin
      gntpar_err_q <= obi_gnt_i ? 1'b0 : (gntpar_err || gntpar_err_q);
    end
  end

  // Shift in on each accepted phase, oldest sits at index cnt_q
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnterr_fifo_q <= '0;
      integ_fifo_q  <= '0;
    end else if (accept) begin
      for (int i = MAX_OUTSTANDING; i >= 2; i--) begin
        gnterr_fifo_q[i] <= gnterr_fifo_q[i-1];
        integ_fifo_q[i]  <= integ_fifo_q[i-1];
      end
      gnterr_fifo_q[1] <= gntpar_err || gntpar_err_q;
      integ_fifo_q[1]  <= integrity_a;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  obi_rchk_check u_rchk_check (
    .rdata_i  (obi_rdata_i),
    .err_i    (obi_err_i),
    .rchk_i   (obi_rchk_i),
    .enable_i (obi_rvalid_i && integrity_en_i),
    .err_o    (rchk_err)
  );

  assign resp_valid_o      = obi_rvalid_i;
  assign resp_rdata_o      = obi_rdata_i;
  assign resp_err_o        = obi_err_i;
  // Flags belong to the transfer being answered
  assign resp_parity_err_o = obi_rvalid_i && (rvalidpar_err || gnterr_fifo_q[cnt_q]);
  assign resp_rchk_err_o   = rchk_err;
  assign resp_integrity_o  = obi_rvalid_i && integ_fifo_q[cnt_q];

  // Immediate alarm on any bus integrity problem
  assign integrity_err_o = rchk_err || rvalidpar_err || gntpar_err;

endmodule

`default_nettype wire

//--- verilog/obi_fetch_arbiter.sv
// Round-robin OBI address phase arbiter with in-order response routing
`timescale 1ns/10ps
`default_nettype none

module obi_fetch_arbiter #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  wire                                                            clk,
  input  wire                                                            rst_n,

  // Port side, indexed by port
  input  wire  [fetch_obi_pkg::NUM_FETCH_PORTS-1:0]                      port_req_i,
  input  wire  [fetch_obi_pkg::NUM_FETCH_PORTS-1:0][31:0]                port_addr_i,
  input  wire  [fetch_obi_pkg::NUM_FETCH_PORTS-1:0][2:0]                 port_prot_i,
  input  wire  [fetch_obi_pkg::NUM_FETCH_PORTS-1:0]                      port_dbg_i,
  input  wire  [fetch_obi_pkg::NUM_FETCH_PORTS-1:0][fetch_obi_pkg::ACHK_W-1:0] port_achk_i,
  output logic [fetch_obi_pkg::NUM_FETCH_PORTS-1:0]                      port_gnt_o,
  output logic [fetch_obi_pkg::NUM_FETCH_PORTS-1:0]                      port_gntpar_o,
  output logic [fetch_obi_pkg::NUM_FETCH_PORTS-1:0]                      port_rvalid_o,
  output logic [fetch_obi_pkg::NUM_FETCH_PORTS-1:0]                      port_rvalidpar_o,

  // Shared bus side
  output logic                                                           bus_req_o,
  output logic                                                           bus_reqpar_o,
  output logic [31:0]                                                    bus_addr_o,
  output logic [2:0]                                                     bus_prot_o,
  output logic                                                           bus_dbg_o,
  output logic [fetch_obi_pkg::ACHK_W-1:0]                               bus_achk_o,
  input  wire                                                            bus_gnt_i,
  input  wire                                                            bus_gntpar_i,
  input  wire                                                            bus_rvalid_i,
  input  wire                                                            bus_rvalidpar_i
);

  import fetch_obi_pkg::*;

  localparam int SEL_W = $clog2(NUM_FETCH_PORTS);
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  // Arbitration state
  logic [SEL_W-1:0] last_q;
  logic [SEL_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [SEL_W-1:0] rr_sel;
  logic [SEL_W-1:0] sel;

  // Routing FIFO of issuing port indices
  logic [MAX_OUTSTANDING-1:0][SEL_W-1:0] route_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             fifo_full;
  logic [SEL_W-1:0] head;
  logic             push;

  ////////////////////////////////////////////////////////////
  // Address phase selection
  ////////////////////////////////////////////////////////////

  // Search from the port after the last grant, nearest wins
  always_comb begin
    int idx;
    rr_sel = last_q;
    for (int off = NUM_FETCH_PORTS; off >= 1; off--) begin
      idx = (int'(last_q) + off) % NUM_FETCH_PORTS;
      if (port_req_i[idx]) begin
        rr_sel = SEL_W'(idx);
      end
    end
  end

  // A pending ungranted phase keeps its owner
  assign sel       = lock_q ? lock_idx_q : rr_sel;
  assign fifo_full = (count_q == CNT_W'(MAX_OUTSTANDING));

  // Masking when full is only possible with no phase locked
  assign bus_req_o    = port_req_i[sel] && (lock_q || !fifo_full);
  assign bus_reqpar_o = ~bus_req_o;
  assign bus_addr_o   = port_addr_i[sel];
  assign bus_prot_o   = port_prot_i[sel];
  assign bus_dbg_o    = port_dbg_i[sel];
  assign bus_achk_o   = port_achk_i[sel];

  assign push = bus_req_o && bus_gnt_i;
  assign head = route_q[rd_ptr_q];

  // Grant to the chosen port, response to the FIFO head
  always_comb begin
    for (int i = 0; i < NUM_FETCH_PORTS; i++) begin
      port_gnt_o[i]       = (sel == SEL_W'(i)) && bus_gnt_i;
      port_gntpar_o[i]    = (sel == SEL_W'(i)) ? bus_gntpar_i : 1'b1;
      port_rvalid_o[i]    = (head == SEL_W'(i)) && bus_rvalid_i;
      port_rvalidpar_o[i] = (head == SEL_W'(i)) ? bus_rvalidpar_i : 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Port 0 comes first after reset
      last_q     <= SEL_W'(NUM_FETCH_PORTS - 1);
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q <= bus_req_o && !bus_gnt_i;
      if (bus_req_o) begin
        lock_idx_q <= sel;
      end
      if (push) begin
        last_q <= sel;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response routing FIFO
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      route_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        route_q[wr_ptr_q] <= sel;
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (bus_rvalid_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, bus_rvalid_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetch_subsys_top.sv
// Instruction fetch subsystem with two OBI adapters sharing one arbitrated OBI bus
`timescale 1ns/10ps
`default_nettype none

module fetch_subsys_top #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  wire                              clk,
  input  wire                              rst_n,

  // Fetch port 0
  input  wire                              fetch0_trans_valid_i,
  output logic                             fetch0_trans_ready_o,
  input  wire [31:0]                       fetch0_trans_addr_i,
  input  wire [2:0]                        fetch0_trans_prot_i,
  input  wire                              fetch0_trans_dbg_i,
  input  wire                              fetch0_trans_integrity_i,
  output logic                             fetch0_resp_valid_o,
  output logic [31:0]                      fetch0_resp_rdata_o,
  output logic                             fetch0_resp_err_o,
  output logic                             fetch0_resp_parity_err_o,
  output logic                             fetch0_resp_rchk_err_o,
  output logic                             fetch0_resp_integrity_o,
  output logic                             fetch0_integrity_err_o,

  // Fetch port 1
  input  wire                              fetch1_trans_valid_i,
  output logic                             fetch1_trans_ready_o,
  input  wire [31:0]                       fetch1_trans_addr_i,
  input  wire [2:0]                        fetch1_trans_prot_i,
  input  wire                              fetch1_trans_dbg_i,
  input  wire                              fetch1_trans_integrity_i,
  output logic                             fetch1_resp_valid_o,
  output logic [31:0]                      fetch1_resp_rdata_o,
  output logic                             fetch1_resp_err_o,
  output logic                             fetch1_resp_parity_err_o,
  output logic                             fetch1_resp_rchk_err_o,
  output logic                             fetch1_resp_integrity_o,
  output logic                             fetch1_integrity_err_o,

  input  wire                              integrity_en_i,

  // Shared OBI bus, master side
  output logic                             obi_req_o,
  output logic                             obi_reqpar_o,
  output logic [31:0]                      obi_addr_o,
  output logic [2:0]                       obi_prot_o,
  output logic                             obi_dbg_o,
  output logic [fetch_obi_pkg::ACHK_W-1:0] obi_achk_o,
  input  wire                              obi_gnt_i,
  input  wire                              obi_gntpar_i,
  input  wire                              obi_rvalid_i,
  input  wire                              obi_rvalidpar_i,
  input  wire [31:0]                       obi_rdata_i,
  input  wire                              obi_err_i,
  input  wire [fetch_obi_pkg::RCHK_W-1:0] obi_rchk_i
);

  import fetch_obi_pkg::*;

  // Adapter to arbiter, indexed by port
  logic [NUM_FETCH_PORTS-1:0]             a_req;
  logic [NUM_FETCH_PORTS-1:0][31:0]       a_addr;
  logic [NUM_FETCH_PORTS-1:0][2:0]        a_prot;
  logic [NUM_FETCH_PORTS-1:0]             a_dbg;
  logic [NUM_FETCH_PORTS-1:0][ACHK_W-1:0] a_achk;
  logic [NUM_FETCH_PORTS-1:0]             a_gnt;
  logic [NUM_FETCH_PORTS-1:0]             a_gntpar;
  logic [NUM_FETCH_PORTS-1:0]             a_rvalid;
  logic [NUM_FETCH_PORTS-1:0]             a_rvalidpar;

  ////////////////////////////////////////////////////////////
  // Fetch adapters
  ////////////////////////////////////////////////////////////

  // Request parity is regenerated on the bus by the arbiter
  obi_instr_adapter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_adapter0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .trans_valid_i     (fetch0_trans_valid_i),
    .trans_ready_o     (fetch0_trans_ready_o),
    .trans_addr_i      (fetch0_trans_addr_i),
    .trans_prot_i      (fetch0_trans_prot_i),
    .trans_dbg_i       (fetch0_trans_dbg_i),
    .trans_integrity_i (fetch0_trans_integrity_i),
    .resp_valid_o      (fetch0_resp_valid_o),
    .resp_rdata_o      (fetch0_resp_rdata_o),
    .resp_err_o        (fetch0_resp_err_o),
    .resp_parity_err_o (fetch0_resp_parity_err_o),
    .resp_rchk_err_o   (fetch0_resp_rchk_err_o),
    .resp_integrity_o  (fetch0_resp_integrity_o),
    .integrity_err_o   (fetch0_integrity_err_o),
    .integrity_en_i    (integrity_en_i),
    .obi_req_o         (a_req[0]),
    .obi_reqpar_o      (),
    .obi_gnt_i         (a_gnt[0]),
    .obi_gntpar_i      (a_gntpar[0]),
    .obi_addr_o        (a_addr[0]),
    .obi_prot_o        (a_prot[0]),
    .obi_dbg_o         (a_dbg[0]),
    .obi_achk_o        (a_achk[0]),
    .obi_rvalid_i      (a_rvalid[0]),
    .obi_rvalidpar_i   (a_rvalidpar[0]),
    .obi_rdata_i       (obi_rdata_i),
    .obi_err_i         (obi_err_i),
    .obi_rchk_i        (obi_rchk_i)
  );

  obi_instr_adapter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_adapter1 (
    .clk               (clk),
    .rst_n             (rst_n),
    .trans_valid_i     (fetch1_trans_valid_i),
    .trans_ready_o     (fetch1_trans_ready_o),
    .trans_addr_i      (fetch1_trans_addr_i),
    .trans_prot_i      (fetch1_trans_prot_i),
    .trans_dbg_i       (fetch1_trans_dbg_i),
    .trans_integrity_i (fetch1_trans_integrity_i),
    .resp_valid_o      (fetch1_resp_valid_o),
    .resp_rdata_o      (fetch1_resp_rdata_o),
    .resp_err_o        (fetch1_resp_err_o),
    .resp_parity_err_o (fetch1_resp_parity_err_o),
    .resp_rchk_err_o   (fetch1_resp_rchk_err_o),
    .resp_integrity_o  (fetch1_resp_integrity_o),
    .integrity_err_o   (fetch1_integrity_err_o),
    .integrity_en_i    (integrity_en_i),
    .obi_req_o         (a_req[1]),
    .obi_reqpar_o      (),
    .obi_gnt_i         (a_gnt[1]),
    .obi_gntpar_i      (a_gntpar[1]),
    .obi_addr_o        (a_addr[1]),
    .obi_prot_o        (a_prot[1]),
    .obi_dbg_o         (a_dbg[1]),
    .obi_achk_o        (a_achk[1]),
    .obi_rvalid_i      (a_rvalid[1]),
    .obi_rvalidpar_i   (a_rvalidpar[1]),
    .obi_rdata_i       (obi_rdata_i),
    .obi_err_i         (obi_err_i),
    .obi_rchk_i        (obi_rchk_i)
  );

  ////////////////////////////////////////////////////////////
  // Shared bus arbiter
  ////////////////////////////////////////////////////////////

  // rdata, err and rchk are broadcast around it
  obi_fetch_arbiter #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .port_req_i       (a_req),
    .port_addr_i      (a_addr),
    .port_prot_i      (a_prot),
    .port_dbg_i       (a_dbg),
    .port_achk_i      (a_achk),
    .port_gnt_o       (a_gnt),
    .port_gntpar_o    (a_gntpar),
    .port_rvalid_o    (a_rvalid),
    .port_rvalidpar_o (a_rvalidpar),
    .bus_req_o        (obi_req_o),
    .bus_reqpar_o     (obi_reqpar_o),
    .bus_addr_o       (obi_addr_o),
    .bus_prot_o       (obi_prot_o),
    .bus_dbg_o        (obi_dbg_o),
    .bus_achk_o       (obi_achk_o),
    .bus_gnt_i        (obi_gnt_i),
    .bus_gntpar_i     (obi_gntpar_i),
    .bus_rvalid_i     (obi_rvalid_i),
    .bus_rvalidpar_i  (obi_rvalidpar_i)
  );

endmodule

`default_nettype wire

//--- verification/tb_fetch_subsys.sv
// Testbench for the fetch subsystem, replaying golden per-cycle vectors against the OBI bus
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_subsys;

  localparam int MAX_VEC = 64;
  localparam int NFIELD  = 29;

  // Fixed sideband for both ports with even parity so achk bit 4 stays clear
  localparam logic [2:0] FETCH_PROT = 3'b100;
  localparam logic       FETCH_DBG  = 1'b1;

  logic clk;
  logic rst_n;

  // Port and slave-side stimulus
  logic        v0, i0, v1, i1, en, gnt, gntpar, rvalid, rvalidpar, rerr;
  logic [31:0] a0, a1, rdata;
  logic [4:0]  rchk;

  wire        rdy0, rdy1, req, reqpar, dbg;
  wire [31:0] addr;
  wire [2:0]  prot;
  wire [5:0]  achk;
  wire        rv0, err0, pe0, ce0, in0, ie0;
  wire        rv1, err1, pe1, ce1, in1, ie1;
  wire [31:0] rd0, rd1;

  // Golden vectors with one row per cycle
  logic [31:0] vec  [0:MAX_VEC-1][0:NFIELD-1];
  string       tags [0:MAX_VEC-1];
  int          nvec;
  int          errors;
  int          test_errs;
  int          ntests;
  int          cycles;
  bit          running;

  fetch_subsys_top #(
    .MAX_OUTSTANDING (2)
  ) dut_i (
    .clk (clk), .rst_n (rst_n),
    .fetch0_trans_valid_i (v0), .fetch0_trans_ready_o (rdy0),
    .fetch0_trans_addr_i (a0), .fetch0_trans_prot_i (FETCH_PROT),
    .fetch0_trans_dbg_i (FETCH_DBG), .fetch0_trans_integrity_i (i0),
    .fetch0_resp_valid_o (rv0), .fetch0_resp_rdata_o (rd0), .fetch0_resp_err_o (err0),
    .fetch0_resp_parity_err_o (pe0), .fetch0_resp_rchk_err_o (ce0),
    .fetch0_resp_integrity_o (in0), .fetch0_integrity_err_o (ie0),
    .fetch1_trans_valid_i (v1), .fetch1_trans_ready_o (rdy1),
    .fetch1_trans_addr_i (a1), .fetch1_trans_prot_i (FETCH_PROT),
    .fetch1_trans_dbg_i (FETCH_DBG), .fetch1_trans_integrity_i (i1),
    .fetch1_resp_valid_o (rv1), .fetch1_resp_rdata_o (rd1), .fetch1_resp_err_o (err1),
    .fetch1_resp_parity_err_o (pe1), .fetch1_resp_rchk_err_o (ce1),
    .fetch1_resp_integrity_o (in1), .fetch1_integrity_err_o (ie1),
    .integrity_en_i (en),
    .obi_req_o (req), .obi_reqpar_o (reqpar), .obi_addr_o (addr), .obi_prot_o (prot),
    .obi_dbg_o (dbg), .obi_achk_o (achk),
    .obi_gnt_i (gnt), .obi_gntpar_i (gntpar), .obi_rvalid_i (rvalid),
    .obi_rvalidpar_i (rvalidpar), .obi_rdata_i (rdata), .obi_err_i (rerr),
    .obi_rchk_i (rchk)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic load_vectors();
    int    fd;
    int    n;
    bit    done;
    bit    bad;
    string tok;
    string rest;
    fd   = $fopen("verification/fetch_golden.txt", "r");
    nvec = 0;
    done = 1'b0;
    if (fd == 0) begin
      $display("Could not open the golden vector file");
    end else begin
      while (!done) begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          done = 1'b1;
        end else if (tok[0] == "#") begin
          // Column notes run to the end of the line
          n = $fgets(rest, fd);
        end else if (nvec < MAX_VEC) begin
          bad = 1'b0;
          for (int j = 0; j < NFIELD; j++) begin
            n = $fscanf(fd, "%h", vec[nvec][j]);
            if (n != 1) begin
              bad = 1'b1;
            end
          end
          if (bad) begin
            $display("Malformed golden row after tag %0s", tok);
            errors++;
          end else begin
            tags[nvec] = tok;
            nvec++;
          end
        end else begin
          $display("Golden file holds more rows than the vector store");
          errors++;
          done = 1'b1;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input int k);
    v0        <= vec[k][0][0];
    a0        <= vec[k][1];
    i0        <= vec[k][2][0];
    v1        <= vec[k][3][0];
    a1        <= vec[k][4];
    i1        <= vec[k][5][0];
    en        <= vec[k][6][0];
    gnt       <= vec[k][7][0];
    gntpar    <= vec[k][8][0];
    rvalid    <= vec[k][9][0];
    rvalidpar <= vec[k][10][0];
    rdata     <= vec[k][11];
    rerr      <= vec[k][12][0];
    rchk      <= vec[k][13][4:0];
  endtask

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic check_vector(input int k);
    compare_value("fetch0_trans_ready_o", vec[k][14], 32'(rdy0));
    compare_value("fetch1_trans_ready_o", vec[k][15], 32'(rdy1));
    compare_value("obi_req_o", vec[k][16], 32'(req));
    compare_value("obi_reqpar_o", {31'b0, ~vec[k][16][0]}, 32'(reqpar));
    // Address phase only carries meaning while req is high
    if (vec[k][16][0]) begin
      compare_value("obi_addr_o", vec[k][17], addr);
      compare_value("obi_achk_o", vec[k][18], 32'(achk));
      compare_value("obi_prot_o", 32'(FETCH_PROT), 32'(prot));
      compare_value("obi_dbg_o", 32'(FETCH_DBG), 32'(dbg));
    end
    compare_value("fetch0_resp_valid_o", vec[k][19], 32'(rv0));
    compare_value("fetch0_resp_parity_err_o", vec[k][20], 32'(pe0));
    compare_value("fetch0_resp_rchk_err_o", vec[k][21], 32'(ce0));
    compare_value("fetch0_resp_integrity_o", vec[k][22], 32'(in0));
    compare_value("fetch0_integrity_err_o", vec[k][23], 32'(ie0));
    compare_value("fetch1_resp_valid_o", vec[k][24], 32'(rv1));
    compare_value("fetch1_resp_parity_err_o", vec[k][25], 32'(pe1));
    compare_value("fetch1_resp_rchk_err_o", vec[k][26], 32'(ce1));
    compare_value("fetch1_resp_integrity_o", vec[k][27], 32'(in1));
    compare_value("fetch1_integrity_err_o", vec[k][28], 32'(ie1));
    // Response payload is broadcast to both ports
    compare_value("fetch0_resp_rdata_o", vec[k][11], rd0);
    compare_value("fetch1_resp_rdata_o", vec[k][11], rd1);
    compare_value("fetch0_resp_err_o", vec[k][12], 32'(err0));
    compare_value("fetch1_resp_err_o", vec[k][12], 32'(err1));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    v0 = 1'b0;
    a0 = '0;
    i0 = 1'b0;
    v1 = 1'b0;
    a1 = '0;
    i1 = 1'b0;
    en = 1'b1;
    gnt = 1'b0;
    gntpar = 1'b1;
    rvalid = 1'b0;
    rvalidpar = 1'b1;
    rdata = '0;
    rerr = 1'b0;
    rchk = '0;
    errors = 0;
    test_errs = 0;
    ntests = 0;
    cycles = 0;
    running = 1'b0;
    load_vectors();
    if (nvec == 0) begin
      $display("No golden vectors were loaded");
      errors++;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    running = 1'b1;
    for (int k = 0; k < nvec; k++) begin
      @(posedge clk);
      drive_vector(k);
      @(negedge clk);
      check_vector(k);
      // Report a test when its last row is done
      if (k == nvec - 1 || tags[k + 1] != tags[k]) begin
        $display("Test %0s finished with %0d errors", tags[k], test_errs);
        ntests++;
        test_errs = 0;
      end
    end
    $display("Summary: %0d tests, %0d cycles, %0d errors", ntests, nvec, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Run limit of vector count plus margin
  always @(posedge clk) begin
    if (running) begin
      cycles <= cycles + 1;
      if (cycles > nvec + 20) begin
        $display("Timeout: the vector run did not end within %0d cycles", nvec + 20);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/fetch_golden.txt
# tag v0 a0 i0 v1 a1 i1 en gnt gntpar rvalid rvalidpar rdata err rchk | expected:
# rdy0 rdy1 req addr achk rv0 pe0 ce0 in0 ie0 rv1 pe1 ce1 in1 ie1 (hex, addr/achk only when req)
passthru 1 00001000 0 0 00000000 0 1 1 0 0 1 00000000 0 00 1 1 1 00001000 22 0 0 0 0 0 0 0 0 0 0
passthru 0 00000000 0 0 00000000 0 1 0 1 1 0 11223344 0 00 1 1 0 00000000 00 1 0 0 0 0 0 0 0 0 0
hold 1 00002000 0 0 00000000 0 1 0 1 0 1 00000000 0 00 1 1 1 00002000 22 0 0 0 0 0 0 0 0 0 0
hold 1 00003000 0 0 00000000 0 1 0 1 0 1 00000000 0 00 0 1 1 00002000 22 0 0 0 0 0 0 0 0 0 0
hold 1 00003000 0 0 00000000 0 1 0 1 0 1 00000000 0 00 0 1 1 00002000 22 0 0 0 0 0 0 0 0 0 0
hold 1 00003000 0 0 00000000 0 1 1 0 0 1 00000000 0 00 0 1 1 00002000 22 0 0 0 0 0 0 0 0 0 0
hold 0 00000000 0 0 00000000 0 1 0 1 1 0 aabbccdd 0 00 1 1 0 00000000 00 1 0 0 0 0 0 0 0 0 0
rrobin 1 00001000 0 1 00000004 1 1 1 0 0 1 00000000 0 00 1 1 1 00000004 21 0 0 0 0 0 0 0 0 0 0
rrobin 0 00000000 0 0 00000000 0 1 1 0 0 1 00000000 0 00 0 1 1 00001000 22 0 0 0 0 0 0 0 0 0 0
rrobin 0 00000000 0 1 00002000 0 1 0 1 0 1 00000000 0 00 1 1 0 00000000 00 0 0 0 0 0 0 0 0 0 0
rrobin 0 00000000 0 0 00000000 0 1 0 1 1 0 11223344 0 00 1 0 0 00000000 00 0 0 0 0 0 1 0 0 1 0
rrobin 0 00000000 0 0 00000000 0 1 1 0 0 1 00000000 0 00 1 0 1 00002000 22 0 0 0 0 0 0 0 0 0 0
rrobin 0 00000000 0 0 00000000 0 1 0 1 1 0 aabbccdd 0 00 1 1 0 00000000 00 1 0 0 0 0 0 0 0 0 0
rrobin 0 00000000 0 0 00000000 0 1 0 1 1 0 01020304 0 0d 1 1 0 00000000 00 0 0 0 0 0 1 0 0 0 0
gntpar 1 00001000 0 0 00000000 0 1 0 0 0 1 00000000 0 00 1 1 1 00001000 22 0 0 0 0 1 0 0 0 0 0
gntpar 0 00000000 0 0 00000000 0 1 1 0 0 1 00000000 0 00 0 1 1 00001000 22 0 0 0 0 0 0 0 0 0 0
gntpar 0 00000000 0 1 00000004 0 1 1 0 0 1 00000000 0 00 1 1 1 00000004 21 0 0 0 0 0 0 0 0 0 0
gntpar 0 00000000 0 0 00000000 0 1 0 1 1 0 11223344 0 00 1 1 0 00000000 00 1 1 0 0 0 0 0 0 0 0
gntpar 0 00000000 0 0 00000000 0 1 0 1 1 0 aabbccdd 0 00 1 1 0 00000000 00 0 0 0 0 0 1 0 0 0 0
rchk 1 00000004 1 0 00000000 0 1 1 0 0 1 00000000 0 00 1 1 1 00000004 21 0 0 0 0 0 0 0 0 0 0
rchk 0 00000000 0 0 00000000 0 1 0 1 1 0 11223344 0 01 1 1 0 00000000 00 1 0 1 1 1 0 0 0 0 0
rchk 1 00001000 0 0 00000000 0 1 1 0 0 1 00000000 0 00 1 1 1 00001000 22 0 0 0 0 0 0 0 0 0 0
rchk 0 00000000 0 0 00000000 0 0 0 1 1 0 11223344 0 01 1 1 0 00000000 00 1 0 0 0 0 0 0 0 0 0
rvpar 0 00000000 0 0 00000000 0 1 0 1 0 0 00000000 0 00 1 1 0 00000000 00 0 0 0 0 1 0 0 0 0 0
rvpar 0 00000000 0 1 00002000 1 1 1 0 0 1 00000000 0 00 1 1 1 00002000 22 0 0 0 0 0 0 0 0 0 0
rvpar 0 00000000 0 0 00000000 0 1 0 1 1 1 aabbccdd 0 00 1 1 0 00000000 00 0 0 0 0 0 1 1 0 1 1
rvpar 0 00000000 0 0 00000000 0 1 0 1 0 1 00000000 0 00 1 1 0 00000000 00 0 0 0 0 0 0 0 0 0 0

//--- vlog.f
verilog/fetch_obi_pkg.sv
verilog/obi_rchk_check.sv
verilog/obi_instr_adapter.sv
verilog/obi_fetch_arbiter.sv
verilog/fetch_subsys_top.sv
verification/tb_fetch_subsys.sv

//--- Makefile
# Verilator simulation of the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_subsys
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --binary -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
